// ==== common/mouse_macros.svh ====
// --------------------------------------------------
// constants for the PS/2 mouse receiver
// include where frame sizes, timers or limits are needed
// --------------------------------------------------
`ifndef MOUSE_MACROS_SVH
`define MOUSE_MACROS_SVH

// one packet is three 11-bit bytes on the line
`define MOUSE_FRAME_BITS 33
`define MOUSE_BYTE_BITS 11

// settling time after every accepted line clock edge
`define MOUSE_DEBOUNCE_CYCLES 150
`define MOUSE_DEBOUNCE_BITS 8

// line silence that closes a packet, longer than any inter-byte gap
`define MOUSE_WATCHDOG_CYCLES 20000
`define MOUSE_WATCHDOG_BITS 15

// cursor coordinate width and the default screen limits
`define MOUSE_POS_BITS 12
`define MOUSE_MAX_X 12'd1023
`define MOUSE_MAX_Y 12'd767

`endif

// ==== common/mouse_pkg.sv ====
// --------------------------------------------------
// shared state encodings and bundles of the mouse receiver
// referenced by scoped names from every RTL block
// --------------------------------------------------
`include "mouse_macros.svh"

package mouse_pkg;

  // debounce machine of the line filter, follows the line clock
  typedef enum logic [2:0] {
    line_clk_high    = 3'd0,
    line_falling     = 3'd1,
    line_falling_wait = 3'd3,
    line_clk_low     = 3'd2,
    line_rising      = 3'd6,
    line_rising_wait = 3'd4
  } line_state_t;

  // frame sequencer states
  typedef enum logic [1:0] {
    seq_wait   = 2'd0,
    seq_gather = 2'd1,
    seq_verify = 2'd3,
    seq_use    = 2'd2
  } seq_state_t;

  // clean edge strobes plus the data bit sampled beside them
  typedef struct packed {
    logic falling;
    logic rising;
    logic data;
  } line_event_t;

  // bit 0 is the first bit seen on the line
  typedef logic [`MOUSE_FRAME_BITS-1:0] frame_t;

  typedef struct packed {
    logic              left;
    logic              right;
    logic signed [8:0] dx;
    logic signed [8:0] dy;
  } motion_t;

  typedef struct packed {
    logic [`MOUSE_POS_BITS-1:0] x;
    logic [`MOUSE_POS_BITS-1:0] y;
    logic                       left;
    logic                       right;
  } cursor_t;

endpackage

// ==== filelist.f ====
+incdir+common
common/mouse_pkg.sv
ps2_rx/ps2_line_filter.sv
ps2_rx/frame_shifter.sv
ps2_rx/frame_decoder.sv
verilog/frame_sequencer.sv
verilog/cursor_tracker.sv
verilog/mouse_top.sv
sim/mouse_checker.sv
sim/tb_mouse.sv

// ==== ps2_rx/frame_decoder.sv ====
// --------------------------------------------------
// checks framing and odd parity of a received packet and
// splits it into button bits and signed X/Y motion
// --------------------------------------------------
`timescale 1ns/1ns
`include "mouse_macros.svh"

module frame_decoder (
  input  mouse_pkg::frame_t  frame,
  output logic               frame_good,
  output mouse_pkg::motion_t motion
);

  localparam int unsigned b0 = 0;
  localparam int unsigned b1 = `MOUSE_BYTE_BITS;
  localparam int unsigned b2 = 2 * `MOUSE_BYTE_BITS;

  logic [2:0] start_ok;
  logic [2:0] stop_ok;
  logic [2:0] parity_ok;
  logic [7:0] header;
  logic [7:0] x_byte;
  logic [7:0] y_byte;

  // every byte opens with a 0 start bit and closes with a 1 stop bit
  assign start_ok = {~frame[b2], ~frame[b1], ~frame[b0]};
  assign stop_ok  = {frame[b2+10], frame[b1+10], frame[b0+10]};

  // data bits plus the parity bit must hold an odd number of ones
  assign parity_ok = {^frame[b2+9:b2+1], ^frame[b1+9:b1+1], ^frame[b0+9:b0+1]};

  assign frame_good = &start_ok && &stop_ok && &parity_ok;

  // data bytes sit between start and parity, LSB first
  assign header = frame[b0+8:b0+1];
  assign x_byte = frame[b1+8:b1+1];
  assign y_byte = frame[b2+8:b2+1];

  // header bit 0 is left, bit 1 right, bits 4 and 5 carry the X and Y signs
  assign motion.left  = header[0];
  assign motion.right = header[1];
  assign motion.dx    = {header[4], x_byte};
  assign motion.dy    = {header[5], y_byte};

endmodule

// ==== ps2_rx/frame_shifter.sv ====
// --------------------------------------------------
// gathers line bits into the 33-bit frame register and
// ends each frame when the line has been quiet long enough
// --------------------------------------------------
`timescale 1ns/1ns
`include "mouse_macros.svh"

module frame_shifter (
  input  logic                   clk,
  input  logic                   reset,
  input  mouse_pkg::line_event_t line_event,
  output mouse_pkg::frame_t      frame,
  output logic                   frame_end,
  output logic                   frame_full,
  output logic                   line_active
);

  localparam int unsigned frame_bits = `MOUSE_FRAME_BITS;
  localparam int unsigned wd_cycles  = `MOUSE_WATCHDOG_CYCLES;

  logic [5:0] bit_count;
  logic [`MOUSE_WATCHDOG_BITS-1:0] wd_count;

  // new bits enter at the top, so the first bit drifts down to bit 0
  always_ff @(posedge clk)
  begin
    if (line_event.falling)
      frame <= {line_event.data, frame[frame_bits-1:1]};
  end

  // --------------------------------------------------
  // bit counter
  // --------------------------------------------------
  // cleared after the watchdog fires so a torn frame cannot leak into the next
  always_ff @(posedge clk)
  begin
    if (reset || frame_end)
      bit_count <= '0;
    else if (line_event.falling && bit_count != 6'h3f)
      bit_count <= bit_count + 1'b1;
  end

  assign frame_full = (bit_count == frame_bits[5:0]);

  // --------------------------------------------------
  // inactivity watchdog
  // --------------------------------------------------
  // starts parked at the end value, so an idle line after reset stays quiet
  always_ff @(posedge clk)
  begin
    if (reset)
      wd_count <= wd_cycles[`MOUSE_WATCHDOG_BITS-1:0];
    else if (line_event.falling || line_event.rising)
      wd_count <= '0;
    else if (wd_count != wd_cycles[`MOUSE_WATCHDOG_BITS-1:0])
      wd_count <= wd_count + 1'b1;
  end

  // the counter passes the last value once per quiet period, giving a single pulse
  assign frame_end = (wd_count == (wd_cycles - 1)
    ? 1'b1 : 1'b0) && !line_event.falling && !line_event.rising;

  // any falling edge tells the sequencer that the line is busy
  assign line_active = line_event.falling;

  // a 34th bit means the line never went quiet between two packets
  a_no_overrun: assert property (@(posedge clk) disable iff (reset)
    line_event.falling |-> bit_count < frame_bits[5:0])
    else $error("frame shifter overrun, more than a full frame without a quiet gap");

endmodule

// ==== ps2_rx/ps2_line_filter.sv ====
// --------------------------------------------------
// synchronises the PS/2 clock and data lines and turns
// the debounced line clock into one-cycle edge strobes
// --------------------------------------------------
`timescale 1ns/1ns
`include "mouse_macros.svh"

module ps2_line_filter (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  ps2_clk,
  input  logic                  ps2_data,
  output mouse_pkg::line_event_t line_event
);

  localparam int unsigned deb_last = `MOUSE_DEBOUNCE_CYCLES - 1;

  logic [1:0] clk_sync;
  logic [1:0] data_sync;
  mouse_pkg::line_state_t state;
  mouse_pkg::line_state_t state_next;
  logic [`MOUSE_DEBOUNCE_BITS-1:0] deb_count;
  logic deb_done;

  // two-flop synchronisers, bit 1 is the usable copy
  always_ff @(posedge clk)
  begin
    clk_sync  <= {clk_sync[0], ps2_clk};
    data_sync <= {data_sync[0], ps2_data};
  end

  // --------------------------------------------------
  // debounce timer
  // --------------------------------------------------
  // restarts on every accepted edge and parks once the settle time is over
  always_ff @(posedge clk)
  begin
    if (reset || line_event.falling || line_event.rising)
      deb_count <= '0;
    else if (!deb_done)
      deb_count <= deb_count + 1'b1;
  end

  assign deb_done = (deb_count == deb_last[`MOUSE_DEBOUNCE_BITS-1:0]);

  // --------------------------------------------------
  // edge state machine
  // --------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (reset)
      state <= mouse_pkg::line_clk_high;
    else
      state <= state_next;
  end

  always_comb
  begin
    state_next = state;
    case (state)
      mouse_pkg::line_clk_high:
        if (!clk_sync[1])
          state_next = mouse_pkg::line_falling;
      mouse_pkg::line_falling:
        state_next = mouse_pkg::line_falling_wait;
      // line bounce during the wait states is ignored
      mouse_pkg::line_falling_wait:
        if (deb_done)
          state_next = mouse_pkg::line_clk_low;
      mouse_pkg::line_clk_low:
        if (clk_sync[1])
          state_next = mouse_pkg::line_rising;
      mouse_pkg::line_rising:
        state_next = mouse_pkg::line_rising_wait;
      mouse_pkg::line_rising_wait:
        if (deb_done)
          state_next = mouse_pkg::line_clk_high;
      default:
        state_next = mouse_pkg::line_clk_high;
    endcase
  end

  // strobes decode straight from the state register, so each lasts one cycle
  assign line_event.falling = (state == mouse_pkg::line_falling);
  assign line_event.rising  = (state == mouse_pkg::line_rising);
  assign line_event.data    = data_sync[1];

  // the frame shifter counts one bit per falling strobe and would miscount a clash
  a_edges_exclusive: assert property (@(posedge clk) disable iff (reset)
    !(line_event.falling && line_event.rising))
    else $error("line filter raised falling and rising strobes together");

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build the PS/2 mouse testbench with Verilator, run it and check the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f filelist.f --top-module tb_mouse --Mdir obj_dir -o tb_mouse
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_mouse > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "CHECKS FAILED" "$LOG"; then
  exit 1
fi
exit 0

// ==== sim/mouse_checker.sv ====
// --------------------------------------------------
// reference cursor model and comparisons for the mouse testbench
// fed expected packets by the testbench while it watches the DUT outputs
// --------------------------------------------------
`timescale 1ns/1ns
`include "mouse_macros.svh"

module mouse_checker (
  input  logic               clk,
  input  logic               reset,
  input  mouse_pkg::cursor_t cursor,
  input  logic               cursor_update,
  input  logic               exp_push,
  input  logic               exp_good,
  input  int                 exp_test,
  input  mouse_pkg::motion_t exp_motion,
  input  logic               finish_req,
  output logic               report_done,
  output int                 error_count
);

  mouse_pkg::cursor_t model;
  mouse_pkg::cursor_t exp_cursor;
  mouse_pkg::cursor_t expect_q[$];
  int test_q[$];
  int test_id;
  int value_errors = 0;
  int other_errors = 0;
  int compared = 0;
  int discarded = 0;
  logic reset_d = 1'b0;

  function automatic string test_name(input int id);
    case (id)
      0: return "reset";
      1: return "random_motion";
      2: return "limits";
      3: return "bad_frame";
      4: return "truncated";
      5: return "buttons";
      default: return "unknown";
    endcase
  endfunction

  // position and both buttons of a cursor as one line of text
  function automatic string cursor_text(input mouse_pkg::cursor_t c);
    return $sformatf("x=%0d y=%0d left=%0b right=%0b", c.x, c.y, c.left, c.right);
  endfunction

  // keeps a moved coordinate on the screen
  function automatic int clamp(input int pos, input int hi);
    if (pos < 0)
      return 0;
    if (pos > hi)
      return hi;
    return pos;
  endfunction

  // screen y grows downward, so a positive dy takes the cursor up toward row 0
  function automatic mouse_pkg::cursor_t apply_motion(input mouse_pkg::cursor_t cur,
                                                      input mouse_pkg::motion_t m);
    mouse_pkg::cursor_t nxt;
    int nx;
    int ny;
    nx = int'(cur.x) + int'($signed(m.dx));
    ny = int'(cur.y) - int'($signed(m.dy));
    nxt.x     = `MOUSE_POS_BITS'(clamp(nx, int'(`MOUSE_MAX_X)));
    nxt.y     = `MOUSE_POS_BITS'(clamp(ny, int'(`MOUSE_MAX_Y)));
    nxt.left  = m.left;
    nxt.right = m.right;
    return nxt;
  endfunction

  // --------------------------------------------------
  // model update and comparison
  // --------------------------------------------------
  always @(posedge clk)
  begin
    reset_d <= reset;
    if (reset)
    begin
      model = '0;
      report_done <= 1'b0;
    end
    else
    begin
      // right after reset the cursor must sit at the origin with buttons released
      if (reset_d && cursor !== '0)
      begin
        value_errors++;
        $display("Error: %s expected %s, actual %s",
          test_name(0), cursor_text('0), cursor_text(cursor));
      end
      if (exp_push)
      begin
        if (exp_good)
        begin
          model = apply_motion(model, exp_motion);
          expect_q.push_back(model);
          test_q.push_back(exp_test);
        end
        else
          discarded++;
      end
      if (cursor_update)
      begin
        if (expect_q.size() == 0)
        begin
          other_errors++;
          $display("cursor update at %0t ns that no good packet explains", $time);
        end
        else
        begin
          exp_cursor = expect_q.pop_front();
          test_id = test_q.pop_front();
          compared++;
          if (cursor !== exp_cursor)
          begin
            value_errors++;
            $display("Error: %s expected %s, actual %s",
              test_name(test_id), cursor_text(exp_cursor), cursor_text(cursor));
          end
        end
      end
      if (finish_req && report_done !== 1'b1)
      begin
        if (expect_q.size() != 0)
        begin
          other_errors += expect_q.size();
          $display("%0d good packets never produced a cursor update", expect_q.size());
        end
        $display("checker: %0d compared, %0d discarded, %0d value errors, %0d other errors",
          compared, discarded, value_errors, other_errors);
        report_done <= 1'b1;
      end
    end
  end

  assign error_count = value_errors + other_errors;

endmodule

// ==== sim/tb_mouse.sv ====
// --------------------------------------------------
// testbench of the PS/2 mouse receiver where a behavioural mouse
// streams random and deliberately broken packets into the DUT
// --------------------------------------------------
`timescale 1ns/1ns
`include "mouse_macros.svh"

module tb_mouse;

  // the line clock half period must outlast the 150-cycle debounce of the filter
  localparam int half_cycles = 200;
  localparam int bit_cycles = 2 * half_cycles;
  localparam int gap_cycles = `MOUSE_WATCHDOG_CYCLES + 2000;
  localparam int packet_cycles = `MOUSE_FRAME_BITS * bit_cycles + gap_cycles;
  localparam int random_packets = 40;
  localparam int limit_packets = 6;
  localparam int button_packets = 8;
  localparam int total_packets = random_packets + 2 * limit_packets + 6 + button_packets;
  localparam int timeout_cycles = 2 * total_packets * packet_cycles;

  logic clk;
  logic reset;
  logic ps2_clk;
  logic ps2_data;
  mouse_pkg::cursor_t cursor;
  logic cursor_update;
  logic exp_push;
  logic exp_good;
  int exp_test;
  mouse_pkg::motion_t exp_motion;
  logic finish_req;
  logic report_done;
  int error_count;
  mouse_pkg::motion_t m;

  mouse_top u_dut (
    .clk           (clk),
    .reset         (reset),
    .ps2_clk       (ps2_clk),
    .ps2_data      (ps2_data),
    .cursor        (cursor),
    .cursor_update (cursor_update)
  );

  mouse_checker u_check (
    .clk           (clk),
    .reset         (reset),
    .cursor        (cursor),
    .cursor_update (cursor_update),
    .exp_push      (exp_push),
    .exp_good      (exp_good),
    .exp_test      (exp_test),
    .exp_motion    (exp_motion),
    .finish_req    (finish_req),
    .report_done   (report_done),
    .error_count   (error_count)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
  endtask

  // --------------------------------------------------
  // behavioural mouse
  // --------------------------------------------------
  // start 0, data LSB first, odd parity, stop 1
  function automatic logic [10:0] make_byte(input logic [7:0] d, input logic flip_parity,
                                            input logic zero_stop);
    return {~zero_stop, (~^d) ^ flip_parity, d, 1'b0};
  endfunction

  function automatic mouse_pkg::motion_t random_motion();
    mouse_pkg::motion_t r;
    r.left  = 1'($urandom);
    r.right = 1'($urandom);
    r.dx    = 9'($urandom);
    r.dy    = 9'($urandom);
    return r;
  endfunction

  // data changes in the middle of the high half, well away from the falling edge
  task automatic send_bit(input logic b);
    @(posedge clk);
    ps2_data <= b;
    wait_cycles(half_cycles / 2);
    ps2_clk <= 1'b0;
    wait_cycles(half_cycles);
    ps2_clk <= 1'b1;
    wait_cycles(half_cycles / 2 - 1);
  endtask

  // header carries the buttons, the always-one bit 3 and the two sign bits
  task automatic send_packet(input int test_id, input mouse_pkg::motion_t mv,
                             input logic bad_parity, input logic bad_stop, input int nbits);
    logic [32:0] line;
    logic good;
    line = {make_byte(mv.dy[7:0], 1'b0, 1'b0),
            make_byte(mv.dx[7:0], 1'b0, bad_stop),
            make_byte({2'b00, mv.dy[8], mv.dx[8], 1'b1, 1'b0, mv.right, mv.left},
                      bad_parity, 1'b0)};
    good = !bad_parity && !bad_stop && (nbits == `MOUSE_FRAME_BITS);
    @(posedge clk);
    exp_push   <= 1'b1;
    exp_good   <= good;
    exp_test   <= test_id;
    exp_motion <= mv;
    @(posedge clk);
    exp_push <= 1'b0;
    for (int i = 0; i < nbits; i++)
      send_bit(line[i]);
    @(posedge clk);
    ps2_data <= 1'b1;
    // quiet line long enough for the DUT watchdog to close the frame
    wait_cycles(gap_cycles);
  endtask

  // --------------------------------------------------
  // stimulus
  // --------------------------------------------------
  initial
  begin
    void'($urandom(91));
    ps2_clk = 1'b1;
    ps2_data = 1'b1;
    reset = 1'b1;
    exp_push = 1'b0;
    exp_good = 1'b0;
    exp_test = 0;
    exp_motion = '0;
    finish_req = 1'b0;
    wait_cycles(16);
    reset <= 1'b0;
    wait_cycles(20);

    for (int i = 0; i < random_packets; i++)
      send_packet(1, random_motion(), 1'b0, 1'b0, `MOUSE_FRAME_BITS);

    // full-scale deltas push the cursor into the lower right and then the upper left corner
    m = '0;
    m.dx = 9'h0ff;
    m.dy = 9'h101;
    for (int i = 0; i < limit_packets; i++)
      send_packet(2, m, 1'b0, 1'b0, `MOUSE_FRAME_BITS);
    m.dx = 9'h101;
    m.dy = 9'h0ff;
    for (int i = 0; i < limit_packets; i++)
      send_packet(2, m, 1'b0, 1'b0, `MOUSE_FRAME_BITS);

    // each broken packet is followed by a good one that must still be taken
    send_packet(3, random_motion(), 1'b1, 1'b0, `MOUSE_FRAME_BITS);
    send_packet(3, random_motion(), 1'b0, 1'b0, `MOUSE_FRAME_BITS);
    send_packet(3, random_motion(), 1'b0, 1'b1, `MOUSE_FRAME_BITS);
    send_packet(3, random_motion(), 1'b0, 1'b0, `MOUSE_FRAME_BITS);

    send_packet(4, random_motion(), 1'b0, 1'b0, 16);
    send_packet(4, random_motion(), 1'b0, 1'b0, `MOUSE_FRAME_BITS);

    for (int i = 0; i < button_packets; i++)
      send_packet(5, random_motion(), 1'b0, 1'b0, `MOUSE_FRAME_BITS);

    wait_cycles(100);
    finish_req <= 1'b1;
    wait (report_done === 1'b1);
    if (error_count == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

  // run limit of twice the length of all packets and their gaps
  initial
  begin
    wait_cycles(timeout_cycles);
    $display("timeout: the run did not finish within %0d clock cycles", timeout_cycles);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

// ==== verilog/cursor_tracker.sv ====
// --------------------------------------------------
// adds each packet's motion to a saturating cursor position
// Y runs downward for video, so upward motion lowers y
// --------------------------------------------------
`timescale 1ns/1ns
`include "mouse_macros.svh"

module cursor_tracker #(
  parameter logic [`MOUSE_POS_BITS-1:0] max_x = `MOUSE_MAX_X,
  parameter logic [`MOUSE_POS_BITS-1:0] max_y = `MOUSE_MAX_Y
) (
  input  logic               clk,
  input  logic               reset,
  input  logic               motion_strobe,
  input  mouse_pkg::motion_t motion,
  output mouse_pkg::cursor_t cursor,
  output logic               cursor_update
);

  logic [8:0] dx_mag;
  logic [8:0] dy_mag;
  logic [`MOUSE_POS_BITS:0] x_up;
  logic [`MOUSE_POS_BITS:0] y_up;
  logic [`MOUSE_POS_BITS-1:0] x_next;
  logic [`MOUSE_POS_BITS-1:0] y_next;

  // magnitudes of the 9-bit deltas, -256 maps to 256
  assign dx_mag = motion.dx[8] ? (~motion.dx + 9'd1) : motion.dx;
  assign dy_mag = motion.dy[8] ? (~motion.dy + 9'd1) : motion.dy;

  // one spare bit so the sum cannot wrap before the clamp
  assign x_up = {1'b0, cursor.x} + {4'b0, dx_mag};
  assign y_up = {1'b0, cursor.y} + {4'b0, dy_mag};

  // --------------------------------------------------
  // saturating update
  // --------------------------------------------------
  always_comb
  begin
    // positive dx moves right and stops at max_x
    if (!motion.dx[8])
      x_next = (x_up > {1'b0, max_x}) ? max_x : x_up[`MOUSE_POS_BITS-1:0];
    else
      x_next = (cursor.x > {3'b0, dx_mag}) ? (cursor.x - {3'b0, dx_mag}) : '0;

    // positive dy means upward, which is toward row 0
    if (!motion.dy[8])
      y_next = (cursor.y > {3'b0, dy_mag}) ? (cursor.y - {3'b0, dy_mag}) : '0;
    else
      y_next = (y_up > {1'b0, max_y}) ? max_y : y_up[`MOUSE_POS_BITS-1:0];
  end

  // position and buttons move together, one cycle after the strobe
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      cursor        <= '0;
      cursor_update <= 1'b0;
    end
    else
    begin
      cursor_update <= motion_strobe;
      if (motion_strobe)
      begin
        cursor.x     <= x_next;
        cursor.y     <= y_next;
        cursor.left  <= motion.left;
        cursor.right <= motion.right;
      end
    end
  end

  // holds across any sequence of packets, not only the one being applied
  a_in_limits: assert property (@(posedge clk) disable iff (reset)
    cursor.x <= max_x && cursor.y <= max_y)
    else $error("cursor left the screen limits");

endmodule

// ==== verilog/frame_sequencer.sv ====
// --------------------------------------------------
// control state machine of the receiver, accepts a frame
// only after a full quiet-terminated run that decodes clean
// --------------------------------------------------
`timescale 1ns/1ns

module frame_sequencer (
  input  logic clk,
  input  logic reset,
  input  logic frame_end,
  input  logic frame_full,
  input  logic line_active,
  input  logic frame_good,
  output logic motion_strobe
);

  mouse_pkg::seq_state_t state;
  mouse_pkg::seq_state_t state_next;

  always_ff @(posedge clk)
  begin
    if (reset)
      state <= mouse_pkg::seq_wait;
    else
      state <= state_next;
  end

  always_comb
  begin
    state_next = state;
    case (state)
      // idle until the mouse starts clocking
      mouse_pkg::seq_wait:
        if (line_active)
          state_next = mouse_pkg::seq_gather;
      // short runs are dropped without any output
      mouse_pkg::seq_gather:
        if (frame_end)
          state_next = frame_full ? mouse_pkg::seq_verify : mouse_pkg::seq_wait;
      mouse_pkg::seq_verify:
        state_next = frame_good ? mouse_pkg::seq_use : mouse_pkg::seq_wait;
      mouse_pkg::seq_use:
        state_next = mouse_pkg::seq_wait;
      default:
        state_next = mouse_pkg::seq_wait;
    endcase
  end

  // the frame register holds still during verify and use, the line is quiet
  assign motion_strobe = (state == mouse_pkg::seq_use);

  // the tracker applies each packet once, a long strobe would double the motion
  a_strobe_single: assert property (@(posedge clk) disable iff (reset)
    motion_strobe |=> !motion_strobe)
    else $error("motion strobe held for more than one cycle");

endmodule

// ==== verilog/mouse_top.sv ====
// --------------------------------------------------
// top level of the PS/2 mouse receiver
// line filter, shifter, decoder, sequencer and cursor tracker
// --------------------------------------------------
`timescale 1ns/1ns
`include "mouse_macros.svh"

module mouse_top (
  input  logic               clk,
  input  logic               reset,
  input  logic               ps2_clk,
  input  logic               ps2_data,
  output mouse_pkg::cursor_t cursor,
  output logic               cursor_update
);

  mouse_pkg::line_event_t line_event;
  mouse_pkg::frame_t      frame;
  mouse_pkg::motion_t     motion;
  logic frame_end;
  logic frame_full;
  logic line_active;
  logic frame_good;
  logic motion_strobe;

  // --------------------------------------------------
  // receive path
  // --------------------------------------------------
  ps2_line_filter u_filter (
    .clk        (clk),
    .reset      (reset),
    .ps2_clk    (ps2_clk),
    .ps2_data   (ps2_data),
    .line_event (line_event)
  );

  frame_shifter u_shifter (
    .clk         (clk),
    .reset       (reset),
    .line_event  (line_event),
    .frame       (frame),
    .frame_end   (frame_end),
    .frame_full  (frame_full),
    .line_active (line_active)
  );

  frame_decoder u_decoder (
    .frame      (frame),
    .frame_good (frame_good),
    .motion     (motion)
  );

  // --------------------------------------------------
  // control and position
  // --------------------------------------------------
  frame_sequencer u_sequencer (
    .clk           (clk),
    .reset         (reset),
    .frame_end     (frame_end),
    .frame_full    (frame_full),
    .line_active   (line_active),
    .frame_good    (frame_good),
    .motion_strobe (motion_strobe)
  );

  cursor_tracker #(
    .max_x (`MOUSE_MAX_X),
    .max_y (`MOUSE_MAX_Y)
  ) u_tracker (
    .clk           (clk),
    .reset         (reset),
    .motion_strobe (motion_strobe),
    .motion        (motion),
    .cursor        (cursor),
    .cursor_update (cursor_update)
  );

endmodule
